// ==== hdl/riscv_consts.svh ====
`ifndef RISCV_CONSTS_SVH
`define RISCV_CONSTS_SVH

// Datapath and address width
`define XLEN 32

// Register file size
`define REG_COUNT 16
`define REG_NUM_W 4

// First fetch address after reset
`define RESET_PC 32'h0000_0000

// PC step per instruction
`define INSTR_BYTES 4

`endif

// ==== hdl/riscvPkg.sv ====
`default_nettype none

`include "riscv_consts.svh"

package riscvPkg;

  // Major opcode classes with their RISC-V encodings
  typedef enum logic [6:0] {
    OP_IMM     = 7'b0010011,
    OP         = 7'b0110011,
    BRANCH     = 7'b1100011,
    LUI        = 7'b0110111,
    AUIPC      = 7'b0010111,
    JAL        = 7'b1101111,
    JALR       = 7'b1100111,
    STORE      = 7'b0100011,
    OP_UNKNOWN = 7'b0000000
  } opcode_e;

  typedef enum logic [3:0] {
    ADD,
    SUB,
    OR,
    XOR,
    AND,
    LESS_U,
    LESS_S,
    SHR_U,
    SHR_S,
    SHL_U,
    SHL_S,
    GE_U,
    GE_S,
    EQ,
    NOT_EQ
  } aluOp_e;

  typedef enum logic [3:0] {
    FETCH0,
    FETCH1,
    DECODE,
    EXECUTE0,
    EXECUTE1,
    EXECUTE2,
    EXECUTE3,
    EXECUTE4
  } seqState_e;

  typedef struct packed {
    opcode_e                opcode;
    logic [2:0]             funct3;
    logic [`REG_NUM_W-1:0]  rd;
    logic [`REG_NUM_W-1:0]  rs1;
    logic [`REG_NUM_W-1:0]  rs2;
    logic [`XLEN-1:0]       imm;
    aluOp_e                 aluOp;
  } decodedInstr_t;

  typedef struct packed {
    logic [`XLEN-1:0]  address;
    logic [`XLEN-1:0]  dataOut;
    logic              writeEnable;   // High for one cycle per store
  } busReq_t;

  typedef struct packed {
    logic              countEnable;
    logic              writeEnable;
    logic              writeAdd;      // Relative load when set
    logic [`XLEN-1:0]  dataIn;
  } pcCtrl_t;

  typedef struct packed {
    logic [`REG_NUM_W-1:0]  num;
    logic                   writeEnable;
    logic [`XLEN-1:0]       dataIn;
  } regCtrl_t;

  typedef struct packed {
    aluOp_e            op;
    logic [`XLEN-1:0]  x;
    logic [`XLEN-1:0]  y;
  } aluReq_t;

endpackage

`default_nettype wire

// ==== hdl/instrDecode.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "riscv_consts.svh"

module instrDecode import riscvPkg::*; (
  input  logic [`XLEN-1:0]  instr,
  output decodedInstr_t     decoded
);

  opcode_e           opClass;
  aluOp_e            aluOp;
  logic [2:0]        funct3;
  logic [`XLEN-1:0]  imm;
  logic [`XLEN-1:0]  immI;
  logic [`XLEN-1:0]  immS;
  logic [`XLEN-1:0]  immB;
  logic [`XLEN-1:0]  immU;
  logic [`XLEN-1:0]  immJ;

  assign funct3 = instr[14:12];

  assign immI = {{20{instr[31]}}, instr[31:20]};
  assign immS = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign immB = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign immU = {instr[31:12], 12'b0};
  assign immJ = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

  always_comb
  begin
    case (instr[6:0])
      OP_IMM, OP, BRANCH, LUI, AUIPC, JAL, JALR, STORE: opClass = opcode_e'(instr[6:0]);
      default:                                          opClass = OP_UNKNOWN;
    endcase
  end

  always_comb
  begin
    case (opClass)
      OP_IMM:      imm = (funct3 == 3'd1 || funct3 == 3'd5) ? {20'b0, instr[31:20]} : immI;
      JALR:        imm = immI;
      STORE:       imm = immS;
      BRANCH:      imm = immB;
      LUI, AUIPC:  imm = immU;
      JAL:         imm = immJ;
      default:     imm = '0;
    endcase
  end

  always_comb
  begin
    aluOp = ADD;   // Address and link arithmetic
    case (opClass)
      OP_IMM, OP:
      begin
        case (funct3)
          3'd0: aluOp = (opClass == OP && instr[30]) ? SUB : ADD;
          3'd1: aluOp = SHL_U;
          3'd2: aluOp = LESS_S;
          3'd3: aluOp = LESS_U;
          3'd4: aluOp = XOR;
          3'd5: aluOp = instr[30] ? SHR_S : SHR_U;   // Bit 30 is imm[10] for srai
          3'd6: aluOp = OR;
          3'd7: aluOp = AND;
        endcase
      end
      BRANCH:
      begin
        case (funct3)
          3'd1:    aluOp = NOT_EQ;
          3'd4:    aluOp = LESS_S;
          3'd5:    aluOp = GE_S;
          3'd6:    aluOp = LESS_U;
          3'd7:    aluOp = GE_U;
          default: aluOp = EQ;
        endcase
      end
      default: aluOp = ADD;
    endcase
  end

  always_comb
  begin
    decoded.opcode = opClass;
    decoded.funct3 = funct3;
    decoded.rd     = instr[7 +: `REG_NUM_W];
    decoded.rs1    = instr[15 +: `REG_NUM_W];
    decoded.rs2    = instr[20 +: `REG_NUM_W];
    decoded.imm    = imm;
    decoded.aluOp  = aluOp;
  end

endmodule

`default_nettype wire

// ==== hdl/aluUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "riscv_consts.svh"

module aluUnit import riscvPkg::*; (
  input  aluReq_t           req,
  output logic [`XLEN-1:0]  result
);

  logic [4:0] shamt;

  assign shamt = req.y[4:0];

  always_comb
  begin
    case (req.op)
      ADD:     result = req.x + req.y;
      SUB:     result = req.x - req.y;
      OR:      result = req.x | req.y;
      XOR:     result = req.x ^ req.y;
      AND:     result = req.x & req.y;
      LESS_U:  result = {{(`XLEN-1){1'b0}}, req.x < req.y};
      LESS_S:  result = {{(`XLEN-1){1'b0}}, $signed(req.x) < $signed(req.y)};
      SHR_U:   result = req.x >> shamt;
      SHR_S:   result = $signed(req.x) >>> shamt;
      SHL_U,
      SHL_S:   result = req.x << shamt;   // No arithmetic left shift
      GE_U:    result = {{(`XLEN-1){1'b0}}, req.x >= req.y};
      GE_S:    result = {{(`XLEN-1){1'b0}}, $signed(req.x) >= $signed(req.y)};
      EQ:      result = {{(`XLEN-1){1'b0}}, req.x == req.y};
      NOT_EQ:  result = {{(`XLEN-1){1'b0}}, req.x != req.y};
      default: result = '0;
    endcase
  end

endmodule

`default_nettype wire

// ==== hdl/registerBank.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "riscv_consts.svh"

module registerBank import riscvPkg::*; (
  input  logic              clk,
  input  logic              reset,
  input  regCtrl_t          ctrl,
  output logic [`XLEN-1:0]  regOut
);

  logic [`XLEN-1:0] regs [`REG_COUNT];

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      for (int i = 0; i < `REG_COUNT; i++)
        regs[i] <= '0;
    end
    else if (ctrl.writeEnable && ctrl.num != '0)   // x0 stays zero
      regs[ctrl.num] <= ctrl.dataIn;
  end

  assign regOut = regs[ctrl.num];

  x0ReadsZero: assert property (@(posedge clk) disable iff (reset)
    ctrl.num == '0 |-> regOut == '0);

endmodule

`default_nettype wire

// ==== hdl/programCounter.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "riscv_consts.svh"

module programCounter import riscvPkg::*; (
  input  logic              clk,
  input  logic              reset,
  input  pcCtrl_t           ctrl,
  output logic [`XLEN-1:0]  pcValue
);

  always_ff @(posedge clk)
  begin
    if (reset)
      pcValue <= `RESET_PC;
    else if (ctrl.countEnable)
      pcValue <= pcValue + `INSTR_BYTES;
    else if (ctrl.writeEnable)
    begin
      if (ctrl.writeAdd)
        pcValue <= pcValue - `INSTR_BYTES + ctrl.dataIn;   // Offset from instruction address
      else
        pcValue <= ctrl.dataIn;
    end
  end

  pcEnablesExclusive: assert property (@(posedge clk) disable iff (reset)
    !(ctrl.countEnable && ctrl.writeEnable));

endmodule

`default_nettype wire

// ==== hdl/storeLaneMerge.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "riscv_consts.svh"

module storeLaneMerge (
  input  logic [`XLEN-1:0]  oldWord,
  input  logic [`XLEN-1:0]  storeData,
  input  logic [2:0]        funct3,
  input  logic [1:0]        byteOffset,
  output logic [`XLEN-1:0]  merged
);

  logic [4:0] bitOffset;

  assign bitOffset = {byteOffset, 3'b000};

  always_comb
  begin
    merged = oldWord;   // Misaligned stores keep the old word
    case (funct3[1:0])
      2'd0: merged[bitOffset +: 8] = storeData[7:0];
      2'd1:
      begin
        if (byteOffset != 2'd3)   // Half must fit in the word
          merged[bitOffset +: 16] = storeData[15:0];
      end
      2'd2:
      begin
        if (byteOffset == 2'd0)
          merged = storeData;
      end
      default: merged = oldWord;
    endcase
  end

endmodule

`default_nettype wire

// ==== hdl/controlSequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "riscv_consts.svh"

module controlSequencer import riscvPkg::*; (
  input  logic              clk,
  input  logic              reset,
  input  decodedInstr_t     decoded,
  input  logic [`XLEN-1:0]  regOut,
  input  logic [`XLEN-1:0]  pcValue,
  input  logic [`XLEN-1:0]  aluResult,
  input  logic [`XLEN-1:0]  mergedWord,
  output busReq_t           bus,
  output pcCtrl_t           pcCtrl,
  output regCtrl_t          regCtrl,
  output aluReq_t           aluReq,
  output logic [2:0]        storeFunct3
);

  seqState_e      state;
  decodedInstr_t  instr;   // Instruction held through execute

  assign storeFunct3 = instr.funct3;

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      state               <= FETCH0;
      bus.writeEnable     <= 1'b0;
      regCtrl.writeEnable <= 1'b0;
      pcCtrl.countEnable  <= 1'b0;
      pcCtrl.writeEnable  <= 1'b0;
      pcCtrl.writeAdd     <= 1'b0;
    end
    else
    begin
      case (state)
        FETCH0:
        begin
          bus.writeEnable     <= 1'b0;
          regCtrl.writeEnable <= 1'b0;
          pcCtrl.writeEnable  <= 1'b0;
          pcCtrl.writeAdd     <= 1'b0;
          bus.address         <= pcValue;
          pcCtrl.countEnable  <= 1'b1;   // PC moves on to the next instruction
          state               <= FETCH1;
        end
        FETCH1:
        begin
          pcCtrl.countEnable <= 1'b0;
          state              <= DECODE;   // Memory answers during DECODE
        end
        DECODE:
        begin
          instr <= decoded;
          state <= EXECUTE0;
        end
        default:
        begin
          state <= FETCH0;
          case (instr.opcode)
            OP_IMM:
            begin
              case (state)
                EXECUTE0:
                begin
                  regCtrl.num <= instr.rs1;
                  aluReq.op   <= instr.aluOp;
                  aluReq.y    <= instr.imm;   // Shift amount sits in the low bits
                  state       <= EXECUTE1;
                end
                EXECUTE1:
                begin
                  aluReq.x    <= regOut;
                  regCtrl.num <= instr.rd;
                  state       <= EXECUTE2;
                end
                default:
                begin
                  regCtrl.dataIn      <= aluResult;
                  regCtrl.writeEnable <= 1'b1;
                end
              endcase
            end
            OP, BRANCH:
            begin
              case (state)
                EXECUTE0:
                begin
                  regCtrl.num <= instr.rs1;
                  aluReq.op   <= instr.aluOp;
                  state       <= EXECUTE1;
                end
                EXECUTE1:
                begin
                  aluReq.x    <= regOut;
                  regCtrl.num <= instr.rs2;
                  state       <= EXECUTE2;
                end
                EXECUTE2:
                begin
                  aluReq.y <= regOut;
                  state    <= EXECUTE3;
                  if (instr.opcode == OP)
                    regCtrl.num <= instr.rd;
                end
                EXECUTE3:
                begin
                  if (instr.opcode == OP)
                  begin
                    regCtrl.dataIn      <= aluResult;
                    regCtrl.writeEnable <= 1'b1;
                  end
                  else
                  begin
                    state <= EXECUTE4;
                    if (aluResult[0])   // Branch taken
                    begin
                      pcCtrl.writeEnable <= 1'b1;
                      pcCtrl.writeAdd    <= 1'b1;
                      pcCtrl.dataIn      <= instr.imm;
                    end
                  end
                end
                default:
                begin
                  pcCtrl.writeEnable <= 1'b0;
                  pcCtrl.writeAdd    <= 1'b0;
                end
              endcase
            end
            LUI:
            begin
              regCtrl.num         <= instr.rd;
              regCtrl.dataIn      <= instr.imm;
              regCtrl.writeEnable <= 1'b1;
            end
            AUIPC:
            begin
              if (state == EXECUTE0)
              begin
                regCtrl.num <= instr.rd;
                aluReq.op   <= instr.aluOp;
                aluReq.x    <= pcValue - `INSTR_BYTES;   // Instruction address
                aluReq.y    <= instr.imm;
                state       <= EXECUTE1;
              end
              else
              begin
                regCtrl.dataIn      <= aluResult;
                regCtrl.writeEnable <= 1'b1;
              end
            end
            JAL:
            begin
              case (state)
                EXECUTE0:
                begin
                  regCtrl.num         <= instr.rd;
                  regCtrl.dataIn      <= pcValue;   // Link is already PC plus 4
                  regCtrl.writeEnable <= 1'b1;
                  aluReq.op           <= instr.aluOp;
                  aluReq.x            <= pcValue - `INSTR_BYTES;
                  aluReq.y            <= instr.imm;
                  state               <= EXECUTE1;
                end
                EXECUTE1:
                begin
                  regCtrl.writeEnable <= 1'b0;
                  pcCtrl.dataIn       <= aluResult;
                  pcCtrl.writeEnable  <= 1'b1;
                  state               <= EXECUTE2;
                end
                default: pcCtrl.writeEnable <= 1'b0;
              endcase
            end
            JALR:
            begin
              case (state)
                EXECUTE0:
                begin
                  regCtrl.num <= instr.rs1;
                  aluReq.op   <= instr.aluOp;
                  aluReq.x    <= instr.imm;
                  state       <= EXECUTE1;
                end
                EXECUTE1:
                begin
                  aluReq.y            <= regOut;
                  regCtrl.num         <= instr.rd;
                  regCtrl.dataIn      <= pcValue;
                  regCtrl.writeEnable <= 1'b1;
                  state               <= EXECUTE2;
                end
                EXECUTE2:
                begin
                  regCtrl.writeEnable <= 1'b0;
                  pcCtrl.dataIn       <= {aluResult[`XLEN-1:1], 1'b0};
                  pcCtrl.writeEnable  <= 1'b1;
                  state               <= EXECUTE3;
                end
                default: pcCtrl.writeEnable <= 1'b0;
              endcase
            end
            STORE:
            begin
              case (state)
                EXECUTE0:
                begin
                  regCtrl.num <= instr.rs1;
                  aluReq.op   <= instr.aluOp;
                  aluReq.x    <= instr.imm;
                  state       <= EXECUTE1;
                end
                EXECUTE1:
                begin
                  aluReq.y    <= regOut;
                  regCtrl.num <= instr.rs2;   // Store data for the merge
                  state       <= EXECUTE2;
                end
                EXECUTE2:
                begin
                  bus.address <= {aluResult[`XLEN-1:2], 2'b00};
                  state       <= EXECUTE3;
                end
                EXECUTE3: state <= EXECUTE4;   // Old word arrives next cycle
                default:
                begin
                  bus.dataOut     <= mergedWord;
                  bus.writeEnable <= 1'b1;
                end
              endcase
            end
            default: state <= FETCH0;   // Unknown opcode does nothing
          endcase
        end
      endcase
    end
  end

  // A store and a register write never share a cycle
  busRegWriteExclusive: assert property (@(posedge clk) disable iff (reset)
    !(bus.writeEnable && regCtrl.writeEnable));

endmodule

`default_nettype wire

// ==== hdl/riscvCore.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "riscv_consts.svh"

module riscvCore import riscvPkg::*; (
  input  logic              clk,
  input  logic              reset,
  input  logic [`XLEN-1:0]  dataIn,
  output busReq_t           bus
);

  decodedInstr_t     decoded;
  pcCtrl_t           pcCtrl;
  regCtrl_t          regCtrl;
  aluReq_t           aluReq;
  logic [`XLEN-1:0]  regOut;
  logic [`XLEN-1:0]  pcValue;
  logic [`XLEN-1:0]  aluResult;
  logic [`XLEN-1:0]  mergedWord;
  logic [2:0]        storeFunct3;

  controlSequencer controlSequencer_i (
    .clk         (clk),
    .reset       (reset),
    .decoded     (decoded),
    .regOut      (regOut),
    .pcValue     (pcValue),
    .aluResult   (aluResult),
    .mergedWord  (mergedWord),
    .bus         (bus),
    .pcCtrl      (pcCtrl),
    .regCtrl     (regCtrl),
    .aluReq      (aluReq),
    .storeFunct3 (storeFunct3)
  );

  instrDecode instrDecode_i (
    .instr   (dataIn),
    .decoded (decoded)
  );

  aluUnit aluUnit_i (
    .req    (aluReq),
    .result (aluResult)
  );

  registerBank registerBank_i (
    .clk    (clk),
    .reset  (reset),
    .ctrl   (regCtrl),
    .regOut (regOut)
  );

  programCounter programCounter_i (
    .clk     (clk),
    .reset   (reset),
    .ctrl    (pcCtrl),
    .pcValue (pcValue)
  );

  // Old word comes straight from the memory read
  storeLaneMerge storeLaneMerge_i (
    .oldWord    (dataIn),
    .storeData  (regOut),
    .funct3     (storeFunct3),
    .byteOffset (aluResult[1:0]),
    .merged     (mergedWord)
  );

endmodule

`default_nettype wire

// ==== dv/coreTb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "riscv_consts.svh"

module coreTb import riscvPkg::*; ();

  localparam logic [31:0] dataAddr     = 32'h0000_0600;
  localparam logic [31:0] skipAddr     = 32'h0000_07f0;   // Written only if a jump fails
  localparam logic [31:0] haltInstr    = 32'h0000_006f;   // jal x0, 0
  localparam int          memWords     = 1024;
  localparam int          storeTimeout = 4000;

  logic              clk;
  logic              reset;
  logic [`XLEN-1:0]  dataIn;
  busReq_t           bus;
  busReq_t           busSample;

  logic [31:0]  mem [memWords];
  logic [31:0]  prog [$];
  logic [31:0]  lcgState;
  busReq_t      expQ [$];
  busReq_t      actQ [$];
  string        nameQ [$];
  int           checkCount;
  int           errorCount;

  riscvCore riscvCore_i (
    .clk    (clk),
    .reset  (reset),
    .dataIn (dataIn),
    .bus    (bus)
  );

  always #2 clk = ~clk;

  always @(negedge clk)
    busSample <= bus;   // Stable copy of the registered bus

  // Memory answers one cycle after the address and takes writes on the edge
  always @(posedge clk)
  begin
    #1;
    if (busSample.writeEnable === 1'b1)
    begin
      mem[busSample.address[11:2]] = busSample.dataOut;
      actQ.push_back(busSample);
    end
    dataIn = mem[busSample.address[11:2]];
  end

  // Pairs each captured write with the next expected one
  always @(negedge clk)
  begin
    if (expQ.size() > 0 && actQ.size() > 0)
      checkStore(nameQ.pop_front(), expQ.pop_front(), actQ.pop_front());
  end

  function automatic logic [31:0] nextRand();
    lcgState = lcgState * 32'd1664525 + 32'd1013904223;
    return lcgState;
  endfunction

  function automatic logic [31:0] rType(input logic [31:0] f7, input logic [31:0] rs2,
                                        input logic [31:0] rs1, input logic [31:0] f3,
                                        input logic [31:0] rd);
    return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
  endfunction

  function automatic logic [31:0] iType(input logic [31:0] imm, input logic [31:0] rs1,
                                        input logic [31:0] f3, input logic [31:0] rd,
                                        input logic [31:0] opcode);
    return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opcode[6:0]};
  endfunction

  function automatic logic [31:0] sType(input logic [31:0] imm, input logic [31:0] rs2,
                                        input logic [31:0] rs1, input logic [31:0] f3);
    return {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] bType(input logic [31:0] imm, input logic [31:0] rs2,
                                        input logic [31:0] rs1, input logic [31:0] f3);
    return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] uType(input logic [31:0] imm, input logic [31:0] rd,
                                        input logic [31:0] opcode);
    return {imm[31:12], rd[4:0], opcode[6:0]};
  endfunction

  function automatic logic [31:0] jType(input logic [31:0] imm, input logic [31:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'b1101111};
  endfunction

  // RISC-V result of an ALU instruction
  function automatic logic [31:0] computeAlu(input logic [2:0] f3, input logic alt,
                                             input logic [31:0] a, input logic [31:0] b);
    logic [31:0] r;
    case (f3)
      3'd0:    r = alt ? a - b : a + b;
      3'd1:    r = a << b[4:0];
      3'd2:    r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'd3:    r = (a < b) ? 32'd1 : 32'd0;
      3'd4:    r = a ^ b;
      3'd5:
      begin
        if (alt)
          r = $signed(a) >>> b[4:0];   // Sign bit fills from the left
        else
          r = a >> b[4:0];
      end
      3'd6:    r = a | b;
      default: r = a & b;
    endcase
    return r;
  endfunction

  function automatic logic isTaken(input logic [2:0] f3, input logic [31:0] a,
                                   input logic [31:0] b);
    case (f3)
      3'd0:    return a == b;
      3'd1:    return a != b;
      3'd4:    return $signed(a) < $signed(b);
      3'd5:    return $signed(a) >= $signed(b);
      3'd6:    return a < b;
      default: return a >= b;
    endcase
  endfunction

  // Misaligned sizes get an empty byte mask
  function automatic logic [31:0] mergeLanes(input logic [31:0] oldWord, input logic [31:0] data,
                                             input logic [2:0] f3, input logic [1:0] offset);
    logic [31:0] mask;
    case (f3)
      3'd0:    mask = 32'h0000_00ff << (8 * offset);
      3'd1:    mask = (offset == 2'd3) ? 32'h0 : 32'h0000_ffff << (8 * offset);
      3'd2:    mask = (offset == 2'd0) ? 32'hffff_ffff : 32'h0;
      default: mask = 32'h0;
    endcase
    return (oldWord & ~mask) | ((data << (8 * offset)) & mask);
  endfunction

  function automatic busReq_t storeRequest(input logic [31:0] addr, input logic [31:0] data);
    busReq_t req;
    req.address     = {addr[31:2], 2'b00};
    req.dataOut     = data;
    req.writeEnable = 1'b1;
    return req;
  endfunction

  task automatic checkStore(input string name, input busReq_t expected, input busReq_t actual);
    checkCount++;
    if (expected !== actual)
    begin
      errorCount++;
      $display("Mismatch %s: expected addr=%h data=%h we=%b, actual addr=%h data=%h we=%b",
               name, expected.address, expected.dataOut, expected.writeEnable,
               actual.address, actual.dataOut, actual.writeEnable);
    end
  endtask

  task automatic emit(input logic [31:0] instr);
    prog.push_back(instr);
  endtask

  task automatic loadConst(input logic [31:0] rd, input logic [31:0] value);
    logic [31:0] upper;
    upper = value + 32'h800;   // Makes up for the sign of the low part
    emit(uType(upper, rd, LUI));
    emit(iType(value, rd, 32'd0, rd, OP_IMM));
  endtask

  task automatic expectStore(input string name, input logic [31:0] addr, input logic [31:0] data);
    nameQ.push_back(name);
    expQ.push_back(storeRequest(addr, data));
  endtask

  task automatic clearTest();
    prog.delete();
    expQ.delete();
    nameQ.delete();
  endtask

  // Loads the program under reset, then runs until every expected store is checked
  task automatic runProgram(input string testName, input logic [31:0] dataWord);
    int cycles;
    int checksBefore;
    int errorsBefore;
    checksBefore = checkCount;
    errorsBefore = errorCount;
    @(posedge clk);
    #1 reset = 1'b1;
    repeat (2) @(posedge clk);
    #1;
    for (int i = 0; i < memWords; i++)
      mem[i] = '0;
    for (int i = 0; i < prog.size(); i++)
      mem[i] = prog[i];
    mem[dataAddr[11:2]] = dataWord;
    actQ.delete();
    repeat (3) @(posedge clk);
    #1 reset = 1'b0;
    cycles = 0;
    while (expQ.size() > 0 && cycles < storeTimeout)
    begin
      @(posedge clk);
      cycles++;
    end
    if (expQ.size() > 0)
    begin
      errorCount++;
      $display("%s: timeout: no store seen, %0d expected stores missing", testName, expQ.size());
      expQ.delete();
      nameQ.delete();
    end
    $display("%-10s %0d checks, %0d errors", testName, checkCount - checksBefore,
             errorCount - errorsBefore);
  endtask

  task automatic immAluTest();
    logic [2:0]   f3List [9] = '{3'd0, 3'd2, 3'd3, 3'd4, 3'd6, 3'd7, 3'd1, 3'd5, 3'd5};
    logic [31:0]  a;
    logic [31:0]  r;
    logic [31:0]  imm;
    logic [31:0]  operand;
    logic         alt;
    int           slot;
    clearTest();
    slot = 0;
    for (int round = 0; round < 2; round++)
    begin
      a = nextRand();
      loadConst(1, a);
      for (int i = 0; i < 9; i++)
      begin
        r   = nextRand();
        alt = (i == 8);   // srai
        if (f3List[i] == 3'd1 || f3List[i] == 3'd5)
        begin
          imm     = {21'b0, alt, 5'b0, r[4:0]};
          operand = {27'b0, r[4:0]};
        end
        else
        begin
          imm     = {{20{r[11]}}, r[11:0]};
          operand = imm;
        end
        emit(iType(imm, 1, f3List[i], 2, OP_IMM));
        emit(sType(dataAddr + 4 * slot, 2, 0, 2));
        expectStore($sformatf("immAlu[%0d]", slot), dataAddr + 4 * slot,
                    computeAlu(f3List[i], alt, a, operand));
        slot++;
      end
    end
    emit(haltInstr);
    runProgram("immAlu", '0);
  endtask

  task automatic regAluTest();
    logic [2:0]   f3List [10] = '{3'd0, 3'd0, 3'd1, 3'd2, 3'd3, 3'd4, 3'd5, 3'd5, 3'd6, 3'd7};
    logic [9:0]   altMask;
    logic [31:0]  a;
    logic [31:0]  b;
    int           slot;
    clearTest();
    altMask = 10'b00_1000_0010;   // sub and sra
    slot    = 0;
    for (int round = 0; round < 3; round++)
    begin
      a = nextRand();
      b = nextRand();
      if (round == 1)
        a = a | 32'h8000_0000;
      if (round == 2)
        b = b | 32'h8000_0000;
      loadConst(1, a);
      loadConst(2, b);
      for (int i = 0; i < 10; i++)
      begin
        emit(rType(altMask[i] ? 32'h20 : 32'h0, 2, 1, f3List[i], 3));
        emit(sType(dataAddr + 4 * slot, 3, 0, 2));
        expectStore($sformatf("regAlu[%0d]", slot), dataAddr + 4 * slot,
                    computeAlu(f3List[i], altMask[i], a, b));
        slot++;
      end
    end
    emit(haltInstr);
    runProgram("regAlu", '0);
  endtask

  task automatic branchTest();
    logic [2:0]   f3List [6] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
    logic [31:0]  a;
    logic [31:0]  b;
    logic [31:0]  x;
    logic [31:0]  y;
    logic [31:0]  addr;
    int           slot;
    clearTest();
    slot = 0;
    emit(iType(1, 0, 0, 5, OP_IMM));   // Fall-through marker
    emit(iType(2, 0, 0, 6, OP_IMM));   // Target marker
    for (int i = 0; i < 6; i++)
    begin
      a = nextRand() | 32'h8000_0000;   // Signed and unsigned orders differ
      b = nextRand() & 32'h7fff_ffff;
      for (int p = 0; p < 3; p++)
      begin
        x    = (p == 2) ? b : a;
        y    = (p == 1) ? b : a;
        addr = dataAddr + 4 * slot;
        loadConst(1, x);
        loadConst(2, y);
        emit(bType(12, 2, 1, f3List[i]));
        emit(sType(addr, 5, 0, 2));
        emit(jType(8, 0));
        emit(sType(addr, 6, 0, 2));
        expectStore($sformatf("branch[%0d]", slot), addr,
                    isTaken(f3List[i], x, y) ? 32'd2 : 32'd1);
        slot++;
      end
    end
    emit(haltInstr);
    runProgram("branch", '0);
  endtask

  task automatic jumpTest();
    logic [31:0]  u1;
    logic [31:0]  u2;
    logic [31:0]  r;
    logic [31:0]  jimm;
    logic [31:0]  jalPc;
    logic [31:0]  target;
    logic [31:0]  auipcPc;
    clearTest();
    u1 = nextRand();
    u2 = nextRand();
    r  = nextRand();
    emit(uType(u1, 7, AUIPC));   // At address 0
    emit(sType(dataAddr, 7, 0, 2));
    expectStore("jump.auipc0", dataAddr, {u1[31:12], 12'b0});
    jalPc = prog.size() * 4;
    emit(jType(12, 8));
    emit(sType(skipAddr, 0, 0, 2));
    emit(sType(skipAddr, 0, 0, 2));
    emit(sType(dataAddr + 4, 8, 0, 2));
    expectStore("jump.jal", dataAddr + 4, jalPc + 4);
    target = prog.size() * 4 + 16;   // Two load words, jalr, one skipped word
    jimm   = {{26{r[5]}}, r[5:0]};
    loadConst(10, target + 1 - jimm);   // Sum has bit 0 set
    emit(iType(jimm, 10, 0, 11, JALR));
    emit(sType(skipAddr, 0, 0, 2));
    emit(sType(dataAddr + 8, 11, 0, 2));
    expectStore("jump.jalr", dataAddr + 8, target - 4);
    auipcPc = prog.size() * 4;
    emit(uType(u2, 12, AUIPC));
    emit(sType(dataAddr + 12, 12, 0, 2));
    expectStore("jump.auipc", dataAddr + 12, auipcPc + {u2[31:12], 12'b0});
    emit(haltInstr);
    runProgram("jump", '0);
  endtask

  task automatic storeLaneTest();
    logic [2:0]   f3List [9] = '{3'd0, 3'd0, 3'd0, 3'd0, 3'd1, 3'd1, 3'd1, 3'd2, 3'd2};
    logic [1:0]   offList [9] = '{2'd0, 2'd1, 2'd2, 2'd3, 2'd0, 2'd2, 2'd3, 2'd1, 2'd0};
    logic [31:0]  oldWord;
    logic [31:0]  cur;
    logic [31:0]  data;
    clearTest();
    oldWord = nextRand();
    cur     = oldWord;
    for (int i = 0; i < 9; i++)
    begin
      data = nextRand();
      loadConst(3, data);
      emit(sType(dataAddr + offList[i], 3, 0, f3List[i]));
      cur = mergeLanes(cur, data, f3List[i], offList[i]);
      expectStore($sformatf("storeLane[%0d]", i), dataAddr, cur);
    end
    emit(haltInstr);
    runProgram("storeLane", oldWord);
  endtask

  initial
  begin
    clk        = 1'b0;
    reset      = 1'b1;
    dataIn     = '0;
    lcgState   = 32'h78aca8a8;
    checkCount = 0;
    errorCount = 0;
    immAluTest();
    regAluTest();
    branchTest();
    jumpTest();
    storeLaneTest();
    $display("Summary: %0d checks, %0d errors", checkCount, errorCount);
    if (errorCount == 0)
      $display("TEST PASS");
    else
      $display("TEST FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+hdl
hdl/riscvPkg.sv
hdl/instrDecode.sv
hdl/aluUnit.sv
hdl/registerBank.sv
hdl/programCounter.sv
hdl/storeLaneMerge.sv
hdl/controlSequencer.sv
hdl/riscvCore.sv
dv/coreTb.sv

// ==== run.sh ====
#!/bin/sh
# Build with Verilator and run; pass only if the testbench reports a pass
cd "$(dirname "$0")" \
  && verilator --binary --timing --assert -Wno-fatal -f verilog.f --top-module coreTb \
       -o coreTbSim \
  && ./obj_dir/coreTbSim | tee /dev/stderr | grep -q "TEST PASS" \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }
